/* rtl/arrayPkg.sv */
//----------------------------------------------------------
// Array memory package
// Sizes, vector types, action and error codes, and the
// request, bank command and response structures
//----------------------------------------------------------
`default_nettype none

package arrayPkg;

  //----------------------------------------------------------
  // Sizes
  //----------------------------------------------------------
  localparam int arrayCount  = 4;                      // Arrays held by the unit
  localparam int indexBits   = 3;
  localparam int arrayLength = 8;                      // Elements per array
  localparam int dataBits    = 12;

  //----------------------------------------------------------
  // Vector types
  //----------------------------------------------------------
  typedef logic [$clog2(arrayCount)-1:0] arrayId_t;    // Array number
  typedef logic [indexBits-1:0]          index_t;      // Position in an array
  typedef logic [indexBits:0]            size_t;       // Size, 0 to arrayLength
  typedef logic [dataBits-1:0]           data_t;       // Element or operand

  //----------------------------------------------------------
  // Codes
  //----------------------------------------------------------
  typedef enum logic [3:0] {
    Clear,                                             // Forget all allocations
    Write,
    Read,
    Size,
    Push,
    Pop,
    Index,                                             // Last match plus one
    Add,                                               // Add and return new value
    Alloc,
    Free
  } action_e;

  typedef enum logic [2:0] {
    None,
    NotAllocated,
    OutOfBounds,
    Full,
    Empty,
    OutOfMemory
  } error_e;

  //----------------------------------------------------------
  // Structures
  //----------------------------------------------------------
  typedef struct packed {
    logic     valid;                                   // One-cycle strobe
    action_e  action;
    arrayId_t array;
    index_t   index;
    data_t    data;
  } request_t;

  typedef struct packed {
    logic    valid;
    action_e action;
    index_t  index;
    data_t   data;
    logic    clearSize;                                // Empty the array on Alloc
  } bankCommand_t;

  typedef struct packed {
    logic   valid;
    data_t  data;
    error_e error;
  } bankResponse_t;

  typedef struct packed {
    logic   valid;
    data_t  data;
    error_e error;
  } response_t;

endpackage

`default_nettype wire

/* rtl/arrayAllocator.sv */
//----------------------------------------------------------
// Array allocator
// Tracks allocated arrays and the freed-array stack, answers
// Alloc, Free and Clear, and routes other actions to banks
//----------------------------------------------------------
`default_nettype none

module arrayAllocator (
  input  wire logic                   clock,
  input  wire logic                   resetN,
  input  wire arrayPkg::request_t     request,
  output arrayPkg::bankCommand_t      commands [arrayPkg::arrayCount],
  output arrayPkg::bankResponse_t     allocResponse
);

  // Allocation state
  logic [arrayPkg::arrayCount-1:0]    allocated;
  logic [$bits(arrayPkg::arrayId_t):0] freshCount;     // Arrays never used so far
  logic [$bits(arrayPkg::arrayId_t):0] stackTop;       // Entries on the freed stack
  arrayPkg::arrayId_t                 freedStack [arrayPkg::arrayCount];

  logic [arrayPkg::arrayCount-1:0]    nextAllocated;
  logic [$bits(arrayPkg::arrayId_t):0] nextFresh;
  logic [$bits(arrayPkg::arrayId_t):0] nextTop;
  logic                               pushFreed;
  logic                               canAlloc;
  arrayPkg::arrayId_t                 chosen;          // Array picked by Alloc

  // Registered command and response fields
  logic [arrayPkg::arrayCount-1:0]    cmdValid;
  logic [arrayPkg::arrayCount-1:0]    cmdClear;
  arrayPkg::action_e                  cmdAction;       // Payload shared by all banks
  arrayPkg::index_t                   cmdIndex;
  arrayPkg::data_t                    cmdData;
  logic                               rspValid;
  arrayPkg::data_t                    rspData;
  arrayPkg::error_e                   rspError;

  logic [arrayPkg::arrayCount-1:0]    nextCmdValid;
  logic [arrayPkg::arrayCount-1:0]    nextCmdClear;
  logic                               nextRspValid;
  arrayPkg::data_t                    nextRspData;
  arrayPkg::error_e                   nextRspError;

  //----------------------------------------------------------
  // Request decode
  //----------------------------------------------------------
  always_comb begin
    nextAllocated = allocated;
    nextFresh     = freshCount;
    nextTop       = stackTop;
    pushFreed     = 1'b0;
    nextCmdValid  = '0;
    nextCmdClear  = '0;
    nextRspValid  = 1'b0;
    nextRspData   = '0;
    nextRspError  = arrayPkg::None;
    canAlloc      = (stackTop != '0) || (freshCount < arrayPkg::arrayCount);
    chosen        = arrayPkg::arrayId_t'(freshCount);
    if (stackTop != '0) begin
      chosen = freedStack[arrayPkg::arrayId_t'(stackTop - 1'b1)];  // Most recently freed
    end
    if (request.valid) begin
      case (request.action)
        arrayPkg::Clear: begin
          nextAllocated = '0;
          nextFresh     = '0;
          nextTop       = '0;
          nextRspValid  = 1'b1;
        end
        arrayPkg::Alloc: begin
          nextRspValid = 1'b1;
          if (canAlloc) begin
            nextAllocated[chosen] = 1'b1;
            nextCmdValid[chosen]  = 1'b1;
            nextCmdClear[chosen]  = 1'b1;                // Bank empties itself
            nextRspData           = arrayPkg::data_t'(chosen);
            if (stackTop != '0) nextTop = stackTop - 1'b1;
            else nextFresh = freshCount + 1'b1;
          end else begin
            nextRspError = arrayPkg::OutOfMemory;
          end
        end
        arrayPkg::Free: begin
          nextRspValid = 1'b1;
          if (allocated[request.array]) begin
            nextAllocated[request.array] = 1'b0;
            nextTop   = stackTop + 1'b1;
            pushFreed = 1'b1;
          end else begin
            nextRspError = arrayPkg::NotAllocated;     // Includes double frees
          end
        end
        default: begin
          if (allocated[request.array]) begin
            nextCmdValid[request.array] = 1'b1;
          end else begin
            nextRspValid = 1'b1;
            nextRspError = arrayPkg::NotAllocated;
          end
        end
      endcase
    end
  end

  //----------------------------------------------------------
  // Registers
  //----------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      allocated  <= '0;
      freshCount <= '0;
      stackTop   <= '0;
      cmdValid   <= '0;
      cmdClear   <= '0;
      rspValid   <= 1'b0;
    end else begin
      allocated  <= nextAllocated;
      freshCount <= nextFresh;
      stackTop   <= nextTop;
      cmdValid   <= nextCmdValid;
      cmdClear   <= nextCmdClear;
      rspValid   <= nextRspValid;
    end
  end

  always_ff @(posedge clock) begin
    if (pushFreed) freedStack[arrayPkg::arrayId_t'(stackTop)] <= request.array;
    cmdAction <= request.action;
    cmdIndex  <= request.index;
    cmdData   <= request.data;
    rspData   <= nextRspData;
    rspError  <= nextRspError;
  end

  always_comb begin
    for (int b = 0; b < arrayPkg::arrayCount; b++) begin
      commands[b] = '{valid: cmdValid[b], action: cmdAction, index: cmdIndex,
                      data: cmdData, clearSize: cmdClear[b]};
    end
  end

  assign allocResponse = '{valid: rspValid, data: rspData, error: rspError};

endmodule

`default_nettype wire

/* rtl/arrayBank.sv */
//----------------------------------------------------------
// Array bank
// Element storage and size of one array, with the element
// and stack operations and their bounds checks
//----------------------------------------------------------
`default_nettype none

module arrayBank (
  input  wire logic                   clock,
  input  wire logic                   resetN,
  input  wire arrayPkg::bankCommand_t command,
  output arrayPkg::bankResponse_t     response
);

  arrayPkg::data_t  memory [arrayPkg::arrayLength];    // Element contents
  arrayPkg::size_t  size;

  // Next-state values
  arrayPkg::size_t  nextSize;
  logic             writeEnable;
  arrayPkg::index_t writeIndex;
  arrayPkg::data_t  writeData;
  arrayPkg::data_t  nextData;
  arrayPkg::error_e nextError;

  // Operation helpers
  logic             inBounds;
  arrayPkg::data_t  sum;
  arrayPkg::size_t  matchPos;                          // Last match plus one
  arrayPkg::index_t topIndex;

  // Registered response fields
  logic             rspValid;
  arrayPkg::data_t  rspData;
  arrayPkg::error_e rspError;

  //----------------------------------------------------------
  // Operation decode
  //----------------------------------------------------------
  always_comb begin
    nextSize    = size;
    writeEnable = 1'b0;
    writeIndex  = command.index;
    writeData   = command.data;
    nextData    = '0;
    nextError   = arrayPkg::None;
    inBounds    = arrayPkg::size_t'(command.index) < size;
    sum         = memory[command.index] + command.data;  // Wraps at 12 bits
    topIndex    = arrayPkg::index_t'(size - 1'b1);
    matchPos    = '0;
    for (int i = 0; i < arrayPkg::arrayLength; i++) begin
      if ((arrayPkg::size_t'(i) < size) && (memory[i] == command.data)) begin
        matchPos = arrayPkg::size_t'(i + 1);
      end
    end

    if (command.valid && command.clearSize) begin
      nextSize = '0;                                   // Fresh allocation
    end else if (command.valid) begin
      case (command.action)
        arrayPkg::Write: begin
          writeEnable = 1'b1;
          nextData    = command.data;
          if (!inBounds) nextSize = arrayPkg::size_t'(command.index) + 1'b1;
        end
        arrayPkg::Read: begin
          if (inBounds) nextData = memory[command.index];
          else nextError = arrayPkg::OutOfBounds;
        end
        arrayPkg::Add: begin
          if (inBounds) begin
            writeEnable = 1'b1;
            writeData   = sum;
            nextData    = sum;
          end else begin
            nextError = arrayPkg::OutOfBounds;
          end
        end
        arrayPkg::Size: begin
          nextData = arrayPkg::data_t'(size);
        end
        arrayPkg::Push: begin
          if (size == arrayPkg::size_t'(arrayPkg::arrayLength)) begin
            nextError = arrayPkg::Full;
          end else begin
            writeEnable = 1'b1;
            writeIndex  = arrayPkg::index_t'(size);      // Append at the end
            nextData    = command.data;
            nextSize    = size + 1'b1;
          end
        end
        arrayPkg::Pop: begin
          if (size == '0) begin
            nextError = arrayPkg::Empty;
          end else begin
            nextData = memory[topIndex];
            nextSize = size - 1'b1;
          end
        end
        arrayPkg::Index: begin
          nextData = arrayPkg::data_t'(matchPos);
        end
        default: begin
          nextData = '0;                               // Not routed to banks
        end
      endcase
    end
  end

  //----------------------------------------------------------
  // Storage and response registers
  //----------------------------------------------------------
  always_ff @(posedge clock) begin
    if (writeEnable) memory[writeIndex] <= writeData;
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      size     <= '0;
      rspValid <= 1'b0;
    end else begin
      size     <= nextSize;
      rspValid <= command.valid && !command.clearSize;  // Allocator answers Alloc
    end
  end

  always_ff @(posedge clock) begin
    rspData  <= nextData;
    rspError <= nextError;
  end

  assign response = '{valid: rspValid, data: rspData, error: rspError};

endmodule

`default_nettype wire

/* rtl/arrayResultSelect.sv */
//----------------------------------------------------------
// Result selector
// Aligns the allocator response with the banks and merges
// the single valid source into the registered response
//----------------------------------------------------------
`default_nettype none

module arrayResultSelect (
  input  wire logic                    clock,
  input  wire logic                    resetN,
  input  wire arrayPkg::bankResponse_t bankResponses [arrayPkg::arrayCount],
  input  wire arrayPkg::bankResponse_t allocResponse,
  output arrayPkg::response_t          response
);

  // Allocator response, one stage late
  logic             delayValid;
  arrayPkg::data_t  delayData;
  arrayPkg::error_e delayError;

  arrayPkg::response_t merged;

  // Registered output fields
  logic             outValid;
  arrayPkg::data_t  outData;
  arrayPkg::error_e outError;

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      delayValid <= 1'b0;
      outValid   <= 1'b0;
    end else begin
      delayValid <= allocResponse.valid;
      outValid   <= merged.valid;
    end
  end

  always_ff @(posedge clock) begin
    delayData  <= allocResponse.data;
    delayError <= allocResponse.error;
    outData    <= merged.data;
    outError   <= merged.error;
  end

  // Only one source is valid per request
  always_comb begin
    merged = '0;
    if (delayValid) begin
      merged = '{valid: 1'b1, data: delayData, error: delayError};
    end
    for (int b = 0; b < arrayPkg::arrayCount; b++) begin
      if (bankResponses[b].valid) begin
        merged = arrayPkg::response_t'(merged | bankResponses[b]);
      end
    end
  end

  assign response = '{valid: outValid, data: outData, error: outError};

endmodule

`default_nettype wire

/* rtl/arrayMemory.sv */
//----------------------------------------------------------
// Array memory unit
// Allocator, one bank per array and the result selector,
// three register stages from request to response
//----------------------------------------------------------
`default_nettype none

module arrayMemory (
  input  wire logic                clock,
  input  wire logic                resetN,
  input  wire arrayPkg::request_t  request,
  output arrayPkg::response_t      response
);

  arrayPkg::bankCommand_t  commands      [arrayPkg::arrayCount];
  arrayPkg::bankResponse_t bankResponses [arrayPkg::arrayCount];
  arrayPkg::bankResponse_t allocResponse;

  // Stage 1
  arrayAllocator allocator0 (
    .clock         (clock),
    .resetN        (resetN),
    .request       (request),
    .commands      (commands),
    .allocResponse (allocResponse)
  );

  // Stage 2, one bank per array
  for (genvar b = 0; b < arrayPkg::arrayCount; b++) begin : bankGen
    arrayBank bank0 (
      .clock    (clock),
      .resetN   (resetN),
      .command  (commands[b]),
      .response (bankResponses[b])
    );
  end

  // Stage 3
  arrayResultSelect select0 (
    .clock         (clock),
    .resetN        (resetN),
    .bankResponses (bankResponses),
    .allocResponse (allocResponse),
    .response      (response)
  );

endmodule

`default_nettype wire

/* bench/arrayMemory_props.sv */
//----------------------------------------------------------
// Array memory properties
// Reset and three-cycle response timing, bound to the top
//----------------------------------------------------------
`default_nettype none

module arrayMemoryProps (
  input wire logic                clock,
  input wire logic                resetN,
  input wire arrayPkg::request_t  request,
  input wire arrayPkg::response_t response
);

  //----------------------------------------------------------
  // Reset
  //----------------------------------------------------------
  quietInReset: assert property (
    @(posedge clock) !resetN |-> !response.valid
  ) else $error("response valid while reset is asserted");

  //----------------------------------------------------------
  // Pipeline timing
  //----------------------------------------------------------
  // Every request is answered three edges later
  answerFollows: assert property (
    @(posedge clock) disable iff (!resetN)
    $past(request.valid, 3) |-> response.valid
  ) else $error("request without a response three cycles later");

  // No response without a request behind it
  noSpuriousAnswer: assert property (
    @(posedge clock) disable iff (!resetN)
    response.valid |-> $past(request.valid, 3)
  ) else $error("response without a request three cycles earlier");

endmodule

bind arrayMemory arrayMemoryProps props0 (
  .clock    (clock),
  .resetN   (resetN),
  .request  (request),
  .response (response)
);

`default_nettype wire

/* bench/arrayMemoryTb.sv */
//----------------------------------------------------------
// Array memory testbench
// Drives allocation, element and stack requests and checks
// every response against a behavioral model
//----------------------------------------------------------
`default_nettype none

module arrayMemoryTb;

  typedef struct packed {
    int                  due;                          // Cycle the response shows up
    arrayPkg::response_t rsp;
  } expect_t;

  logic                clock;
  logic                resetN;
  arrayPkg::request_t  request;
  arrayPkg::response_t response;

  expect_t          expected [$];                      // Outstanding requests in order
  expect_t          head;
  arrayPkg::error_e gotError;
  arrayPkg::error_e wantError;
  int               cycle = 0;
  int               errors = 0;
  int               checks = 0;
  int               tests = 0;
  int               testErrors = 0;
  logic [31:0]      randState = 32'h5f1803a8;

  // Reference model state
  logic [arrayPkg::arrayCount-1:0] allocated;
  int                              freshCount;
  arrayPkg::arrayId_t              freedStack [$];
  int                              sizes [arrayPkg::arrayCount];
  arrayPkg::data_t                 memory [arrayPkg::arrayCount][arrayPkg::arrayLength];

  arrayMemory dut0 (
    .clock    (clock),
    .resetN   (resetN),
    .request  (request),
    .response (response)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  always @(posedge clock) cycle <= cycle + 1;

  function automatic logic [31:0] xorshift(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] nextRandom();
    randState = xorshift(randState);
    return randState;
  endfunction

  //----------------------------------------------------------
  // Behavioral model applied in request order
  //----------------------------------------------------------
  task automatic predict(input arrayPkg::action_e action, input arrayPkg::arrayId_t array,
                         input arrayPkg::index_t index, input arrayPkg::data_t data,
                         output arrayPkg::response_t rsp);
    int i;
    int p;
    int chosen;
    i = int'(index);
    chosen = -1;
    rsp = '{valid: 1'b1, data: '0, error: arrayPkg::None};
    if (action == arrayPkg::Clear) begin
      allocated  = '0;
      freshCount = 0;
      freedStack.delete();
    end else if (action == arrayPkg::Alloc) begin
      if (freedStack.size() > 0) begin
        chosen = int'(freedStack.pop_back());          // Last freed comes back first
      end else if (freshCount < arrayPkg::arrayCount) begin
        chosen = freshCount;
        freshCount++;
      end
      if (chosen < 0) begin
        rsp.error = arrayPkg::OutOfMemory;
      end else begin
        allocated[chosen] = 1'b1;
        sizes[chosen]     = 0;
        rsp.data          = arrayPkg::data_t'(chosen);
      end
    end else if (!allocated[array]) begin
      rsp.error = arrayPkg::NotAllocated;
    end else begin
      case (action)
        arrayPkg::Free: begin
          allocated[array] = 1'b0;
          freedStack.push_back(array);
        end
        arrayPkg::Write: begin
          memory[array][i] = data;
          if (i >= sizes[array]) sizes[array] = i + 1;
          rsp.data = data;
        end
        arrayPkg::Read: begin
          if (i < sizes[array]) rsp.data = memory[array][i];
          else rsp.error = arrayPkg::OutOfBounds;
        end
        arrayPkg::Add: begin
          if (i < sizes[array]) begin
            memory[array][i] = memory[array][i] + data;  // 12-bit wrap
            rsp.data = memory[array][i];
          end else begin
            rsp.error = arrayPkg::OutOfBounds;
          end
        end
        arrayPkg::Size: rsp.data = arrayPkg::data_t'(sizes[array]);
        arrayPkg::Push: begin
          if (sizes[array] == arrayPkg::arrayLength) begin
            rsp.error = arrayPkg::Full;
          end else begin
            memory[array][sizes[array]] = data;
            sizes[array]++;
            rsp.data = data;
          end
        end
        arrayPkg::Pop: begin
          if (sizes[array] == 0) begin
            rsp.error = arrayPkg::Empty;
          end else begin
            sizes[array]--;
            rsp.data = memory[array][sizes[array]];
          end
        end
        default: begin
          for (p = 0; p < sizes[array]; p++) begin
            if (memory[array][p] == data) rsp.data = arrayPkg::data_t'(p + 1);
          end
        end
      endcase
    end
  endtask

  task automatic send(input arrayPkg::action_e action, input arrayPkg::arrayId_t array,
                      input arrayPkg::index_t index, input arrayPkg::data_t data);
    expect_t entry;
    @(posedge clock);
    #2;
    request = '{valid: 1'b1, action: action, array: array, index: index, data: data};
    predict(action, array, index, data, entry.rsp);
    entry.due = cycle + 3;                             // Three edges to the output
    expected.push_back(entry);
  endtask

  task automatic finishRun();
    $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    @(posedge clock);
    #2;
    request.valid = 1'b0;
    while (expected.size() != 0 && waited < 20) begin
      @(posedge clock);
      waited++;
    end
    if (expected.size() != 0) begin
      $display("Timeout at %0t with %0d responses outstanding", $time, expected.size());
      errors++;
      expected.delete();
    end
  endtask

  task automatic endTest(input string name);
    drain();
    tests++;
    if (errors == testErrors) $display("Test %0d %s: ok", tests, name);
    else $display("Test %0d %s: %0d errors", tests, name, errors - testErrors);
    testErrors = errors;
  endtask

  //----------------------------------------------------------
  // Response checks
  //----------------------------------------------------------
  always @(negedge clock) begin
    if (resetN) begin
      if (response.valid) begin
        if (expected.size() == 0) begin
          $display("Response at %0t without an outstanding request", $time);
          errors++;
        end else begin
          head      = expected.pop_front();
          gotError  = response.error;
          wantError = head.rsp.error;
          checks++;
          assert (cycle == head.due) else begin
            $display("Response at %0t came at cycle %0d instead of %0d", $time, cycle,
                     head.due);
            errors++;
          end
          assert (gotError == wantError) else begin
            $display("Fail %0t response.error expected %s got %s", $time, wantError.name(),
                     gotError.name());
            errors++;
          end
          assert (response.data == head.rsp.data) else begin
            $display("Fail %0t response.data expected %h got %h", $time, head.rsp.data,
                     response.data);
            errors++;
          end
        end
      end else if (expected.size() != 0 && expected[0].due <= cycle) begin
        $display("Response missing at %0t for cycle %0d", $time, expected[0].due);
        head = expected.pop_front();
        errors++;
      end
    end
  end

  //----------------------------------------------------------
  // Stimulus
  //----------------------------------------------------------
  initial begin : stimulus
    int written [$];
    arrayPkg::index_t idx;
    arrayPkg::data_t value;
    resetN     = 1'b0;
    request    = '0;
    allocated  = '0;
    freshCount = 0;
    for (int a = 0; a < arrayPkg::arrayCount; a++) begin
      sizes[a] = 0;
      for (int e = 0; e < arrayPkg::arrayLength; e++) memory[a][e] = '0;
    end
    repeat (16) @(posedge clock);
    #2;
    resetN = 1'b1;

    for (int i = 0; i < 5; i++) send(arrayPkg::Alloc, 2'd0, 3'd0, 12'd0);
    endTest("alloc until out of memory");

    for (int i = 0; i < 5; i++) begin
      idx = arrayPkg::index_t'(nextRandom() % 6);     // Keeps index 7 past the end
      send(arrayPkg::Write, 2'd0, idx, arrayPkg::data_t'(nextRandom()));
      written.push_back(int'(idx));
    end
    foreach (written[i]) send(arrayPkg::Read, 2'd0, arrayPkg::index_t'(written[i]), 12'd0);
    send(arrayPkg::Size, 2'd0, 3'd0, 12'd0);
    send(arrayPkg::Read, 2'd0, arrayPkg::index_t'(sizes[0]), 12'd0);
    send(arrayPkg::Read, 2'd0, 3'd7, 12'd0);
    endTest("write, read and size");

    for (int i = 0; i < 9; i++) send(arrayPkg::Push, 2'd3, 3'd0, arrayPkg::data_t'(nextRandom()));
    for (int i = 0; i < 9; i++) send(arrayPkg::Pop, 2'd3, 3'd0, 12'd0);
    endTest("push to full, pop to empty");

    send(arrayPkg::Free, 2'd1, 3'd0, 12'd0);
    send(arrayPkg::Free, 2'd2, 3'd0, 12'd0);
    send(arrayPkg::Read, 2'd1, 3'd0, 12'd0);
    send(arrayPkg::Free, 2'd1, 3'd0, 12'd0);         // Double free
    send(arrayPkg::Alloc, 2'd0, 3'd0, 12'd0);
    send(arrayPkg::Alloc, 2'd0, 3'd0, 12'd0);
    send(arrayPkg::Clear, 2'd0, 3'd0, 12'd0);
    send(arrayPkg::Alloc, 2'd0, 3'd0, 12'd0);
    endTest("free, realloc and clear");

    for (int i = 0; i < 8; i++) begin
      value = (arrayPkg::data_t'(nextRandom()) & 12'h0ff) | 12'h100;
      if (i == 2 || i == 5) value = 12'h3a5;
      if (i == 7) value = 12'hff0;                     // Overflows on the add below
      send(arrayPkg::Write, 2'd0, arrayPkg::index_t'(i), value);
    end
    send(arrayPkg::Index, 2'd0, 3'd0, 12'h3a5);
    send(arrayPkg::Index, 2'd0, 3'd0, 12'h7ff);
    send(arrayPkg::Add, 2'd0, 3'd7, 12'h020);
    send(arrayPkg::Read, 2'd0, 3'd7, 12'd0);
    idx = arrayPkg::index_t'(nextRandom() % 7);
    send(arrayPkg::Add, 2'd0, idx, arrayPkg::data_t'(nextRandom()));
    send(arrayPkg::Read, 2'd0, idx, 12'd0);
    endTest("index and add");

    send(arrayPkg::Alloc, 2'd0, 3'd0, 12'd0);
    for (int i = 0; i < 12; i++) begin
      idx   = arrayPkg::index_t'(nextRandom());
      value = arrayPkg::data_t'(nextRandom());
      send(arrayPkg::Write, arrayPkg::arrayId_t'(i % 2), idx, value);
      send(arrayPkg::Read, arrayPkg::arrayId_t'(i % 2), idx, 12'd0);
      send(arrayPkg::Add, arrayPkg::arrayId_t'(i % 2), idx, arrayPkg::data_t'(nextRandom()));
    end
    send(arrayPkg::Size, 2'd1, 3'd0, 12'd0);
    send(arrayPkg::Index, 2'd0, 3'd0, value);
    endTest("back-to-back mixed banks");

    finishRun();
  end

endmodule

`default_nettype wire

/* project.f */
rtl/arrayPkg.sv
rtl/arrayAllocator.sv
rtl/arrayBank.sv
rtl/arrayResultSelect.sv
rtl/arrayMemory.sv
bench/arrayMemory_props.sv
bench/arrayMemoryTb.sv

/* run.sh */
#!/bin/sh
# Build and run the array memory testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f project.f --top-module arrayMemoryTb -o arrayMemorySim

./obj_dir/arrayMemorySim | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi

if ! grep -q "TESTBENCH PASSED" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi

echo "Simulation passed"
